//--- Bender.yml
package:
  name: hello

sources:
  - include_dirs:
      - source
    files:
      - source/hello_pkg.sv
      - source/hello_csr.sv
      - source/hello_ctrl.sv
      - source/hello_writer.sv
      - source/hello_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verif/hello_tb_clock.sv
      - verif/hello_chk.sv
      - verif/hello_tb.sv

//--- compile.f
+incdir+source
source/hello_pkg.sv
source/hello_csr.sv
source/hello_ctrl.sv
source/hello_writer.sv
source/hello_top.sv
verif/hello_tb_clock.sv
verif/hello_chk.sv
verif/hello_tb.sv

//--- verif/hello_tb.sv
/*
 * Hello accelerator testbench
 * Random MMIO traffic and memory back-pressure checked against a reference model
 */

`include "hello_settings.svh"

module hello_tb import hello_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD_NS = 40;
    localparam int RANDOM_JOBS   = 12;
    localparam int MAX_LINES     = 16;
    // Generous cycle budget per line at the heaviest stall duty of 3 in 4
    localparam int STALL_BOUND   = 32;
    localparam int MARGIN_CYCLES = 2000;
    localparam longint WATCHDOG_NS =
        longint'((RANDOM_JOBS + 1) * MAX_LINES * STALL_BOUND + MARGIN_CYCLES) * CLK_PERIOD_NS;

    localparam logic [127:0] AFU_ID = `HELLO_AFU_ID;
    // Feature type 1 in bits 63:60, end of list in bit 40
    localparam t_mmio_data DFH_WORD = 64'h1000_0100_0000_0000;

    logic       clk;
    logic       reset_n;
    logic       mmio_read;
    logic       mmio_write;
    t_mmio_addr mmio_address;
    t_mmio_data mmio_writedata;
    logic       mmio_readdatavalid;
    t_mmio_data mmio_readdata;
    logic       mmio_writeresponsevalid;
    logic       wr_waitrequest;
    logic       wr_write;
    t_mem_addr  wr_address;
    t_line      wr_writedata;

    // Reference model state, always what the DUT holds between two rising edges
    logic [31:0] rng_state;
    logic        model_busy;
    t_count      model_lines;
    t_count      model_count;
    logic        start_pending;
    logic        accept_pending;
    logic        read_pending;
    logic        read_is_status;
    t_mmio_data  read_expected;
    logic        write_pending;
    int          stall_duty;
    t_mem_addr   exp_addr_q[$];
    t_line       exp_line_q[$];

    hello_tb_clock #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(16)) clock_gen
    (
        .clk     (clk),
        .reset_n (reset_n)
    );

    hello_top hello_top_inst
    (
        .clk                     (clk),
        .reset_n                 (reset_n),
        .mmio_read               (mmio_read),
        .mmio_write              (mmio_write),
        .mmio_address            (mmio_address),
        .mmio_writedata          (mmio_writedata),
        .mmio_readdatavalid      (mmio_readdatavalid),
        .mmio_readdata           (mmio_readdata),
        .mmio_writeresponsevalid (mmio_writeresponsevalid),
        .wr_waitrequest          (wr_waitrequest),
        .wr_write                (wr_write),
        .wr_address              (wr_address),
        .wr_writedata            (wr_writedata)
    );

    // ==================================================
    // Helpers and reference model
    // ==================================================

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic t_mmio_data status_word(logic busy, t_count lines);
        t_mmio_data word;
        word       = '0;
        word[0]    = busy;
        word[15:8] = lines;
        return word;
    endfunction

    function automatic t_mmio_data predict_read(t_mmio_addr index);
        case (index)
            4'd0:    return DFH_WORD;
            4'd1:    return AFU_ID[63:0];
            4'd2:    return AFU_ID[127:64];
            4'd5:    return status_word(model_busy, model_lines);
            default: return '0;
        endcase
    endfunction

    // Greeting in the low bytes and the line index in the top byte
    function automatic t_line greeting_line(t_count index);
        t_line line;
        line = '0;
        line[`HELLO_GREETING_WIDTH-1:0] = `HELLO_GREETING;
        line[`HELLO_LINE_WIDTH-1 -: `HELLO_COUNT_WIDTH] = index;
        return line;
    endfunction

    task automatic stop_run(string text);
        $display("%s", text);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(string what);
        stop_run($sformatf("[FAIL] %0d ns: %s", $time, what));
    endtask

    task automatic compare_mmio_read(t_mmio_data actual, t_mmio_data expected);
        if (actual !== expected)
        begin
            report_mismatch($sformatf("MMIO read data %h, expected %h", actual, expected));
        end
    endtask

    task automatic compare_status(t_mmio_data actual, t_mmio_data expected);
        if (actual !== expected)
        begin
            report_mismatch($sformatf("Status busy %0b lines %0d, expected busy %0b lines %0d",
                actual[0], actual[15:8], expected[0], expected[15:8]));
        end
    endtask

    task automatic compare_line(t_mem_addr actual_addr, t_line actual_data,
                                t_mem_addr expected_addr, t_line expected_data);
        if (actual_addr !== expected_addr)
        begin
            report_mismatch($sformatf("Line address %h, expected %h", actual_addr, expected_addr));
        end
        if (actual_data !== expected_data)
        begin
            report_mismatch($sformatf("Line data at %h is %h, expected %h",
                actual_addr, actual_data, expected_data));
        end
    endtask

    task automatic compare_flag(logic actual, logic expected, string name);
        if (actual !== expected)
        begin
            report_mismatch($sformatf("%s is %b, expected %b", name, actual, expected));
        end
    endtask

    // Queue the C+1 lines that a job started now must write
    task automatic expect_job_lines(t_mem_addr base, t_count count);
        for (int i = 0; i <= count; i++)
        begin
            exp_addr_q.push_back(base + t_mem_addr'(i));
            exp_line_q.push_back(greeting_line(t_count'(i)));
        end
    endtask

    // ==================================================
    // Cycle engine
    // ==================================================

    // Moves to the next falling edge, checks what the rising edge produced,
    // then drives a fresh waitrequest and predicts the coming handshake
    task automatic tick();
        @(negedge clk);
        if (hello_top_inst.hello_chk_inst.assert_failures != 0)
        begin
            stop_run("A protocol assertion failed in the bound checker");
        end
        if (start_pending)
        begin
            model_busy    = 1'b1;
            model_lines   = '0;
            start_pending = 1'b0;
        end
        if (accept_pending)
        begin
            model_lines    = model_lines + 1'b1;
            accept_pending = 1'b0;
            if (model_lines == t_count'(model_count + 1'b1))
            begin
                model_busy = 1'b0;
            end
        end
        compare_flag(mmio_readdatavalid, read_pending, "mmio_readdatavalid");
        if (read_pending && read_is_status)
        begin
            compare_status(mmio_readdata, read_expected);
        end
        else if (read_pending)
        begin
            compare_mmio_read(mmio_readdata, read_expected);
        end
        compare_flag(mmio_writeresponsevalid, write_pending, "mmio_writeresponsevalid");
        compare_flag(wr_write, model_busy, "wr_write");
        mmio_read     = 1'b0;
        mmio_write    = 1'b0;
        read_pending  = 1'b0;
        write_pending = 1'b0;
        wr_waitrequest = (next_random() % 4) < stall_duty;
        // A line offered with waitrequest low is taken on the next rising edge
        if (wr_write && !wr_waitrequest)
        begin
            if (exp_line_q.size() == 0)
            begin
                stop_run("The DUT wrote a memory line that no job asked for");
            end
            compare_line(wr_address, wr_writedata, exp_addr_q.pop_front(), exp_line_q.pop_front());
            accept_pending = 1'b1;
        end
    endtask

    task automatic mmio_read_op(t_mmio_addr index);
        mmio_read      = 1'b1;
        mmio_address   = index;
        read_pending   = 1'b1;
        read_is_status = (index == CSR_STATUS);
        read_expected  = predict_read(index);
        tick();
    endtask

    task automatic expect_status_read(logic busy, t_count lines);
        mmio_read      = 1'b1;
        mmio_address   = CSR_STATUS;
        read_pending   = 1'b1;
        read_is_status = 1'b1;
        read_expected  = status_word(busy, lines);
        tick();
    endtask

    // Writes change registers only while idle; an idle address write starts a job
    task automatic mmio_write_op(t_mmio_addr index, t_mmio_data data);
        mmio_write     = 1'b1;
        mmio_address   = index;
        mmio_writedata = data;
        write_pending  = 1'b1;
        if (!model_busy && index == CSR_MEM_ADDR)
        begin
            start_pending = 1'b1;
            expect_job_lines(t_mem_addr'(data), model_count);
        end
        else if (!model_busy && index == CSR_LINE_COUNT)
        begin
            model_count = t_count'(data);
        end
        tick();
    endtask

    task automatic random_op();
        logic [31:0] r;
        r = next_random();
        case (r[2:0])
            3'd0, 3'd1, 3'd2: tick();
            3'd3, 3'd4:       mmio_read_op(t_mmio_addr'(r[11:8]));
            3'd5:             mmio_read_op(CSR_STATUS);
            3'd6:             mmio_write_op(t_mmio_addr'(r[9:8]), {next_random(), next_random()});
            default:          mmio_write_op(CSR_MEM_ADDR, t_mmio_data'(next_random()));
        endcase
    endtask

    task automatic run_job();
        t_count    count;
        t_mem_addr base;
        count      = t_count'(next_random() % MAX_LINES);
        base       = next_random();
        stall_duty = next_random() % 4;
        mmio_write_op(CSR_LINE_COUNT, t_mmio_data'(count));
        mmio_write_op(CSR_MEM_ADDR, t_mmio_data'(base));
        mmio_read_op(CSR_STATUS);
        // A second address write must not restart a running job
        if (wr_write)
        begin
            mmio_write_op(CSR_MEM_ADDR, t_mmio_data'(next_random()));
        end
        while (wr_write)
        begin
            random_op();
        end
        expect_status_read(1'b0, t_count'(count + 1'b1));
        if (exp_line_q.size() != 0)
        begin
            stop_run("A job ended before all of its memory lines were written");
        end
    endtask

    // ==================================================
    // Test sequence and watchdog
    // ==================================================

    initial
    begin
        #(WATCHDOG_NS);
        stop_run("The watchdog expired before the tests finished");
    end

    initial
    begin
        rng_state      = 32'had1c_823b;
        mmio_read      = 1'b0;
        mmio_write     = 1'b0;
        mmio_address   = '0;
        mmio_writedata = '0;
        wr_waitrequest = 1'b0;
        model_busy     = 1'b0;
        model_lines    = '0;
        model_count    = '0;
        start_pending  = 1'b0;
        accept_pending = 1'b0;
        read_pending   = 1'b0;
        read_is_status = 1'b0;
        read_expected  = '0;
        write_pending  = 1'b0;
        stall_duty     = 2;
        @(posedge reset_n);
        tick();

        // Count register still at its reset value, so this job is one line
        mmio_write_op(CSR_MEM_ADDR, t_mmio_data'(next_random()));
        while (wr_write)
        begin
            tick();
        end
        expect_status_read(1'b0, 8'd1);
        if (exp_line_q.size() != 0)
        begin
            stop_run("The first job after reset did not write its single line");
        end

        // Whole read space back to back, then a write to an unmapped word
        for (int i = 0; i < 16; i++)
        begin
            mmio_read_op(t_mmio_addr'(i));
        end
        mmio_write_op(t_mmio_addr'(9), {next_random(), next_random()});

        for (int j = 0; j < RANDOM_JOBS; j++)
        begin
            run_job();
        end
        tick();

        if (hello_top_inst.hello_chk_inst.assert_failures == 0)
        begin
            $display("Test completed successfully");
            $finish;
        end
        else
        begin
            stop_run("A protocol assertion failed in the bound checker");
        end
    end

endmodule

//--- verif/hello_chk.sv
/*
 * Hello protocol checker
 * MMIO response timing, memory request stability and FSM consistency
 */

module hello_chk import hello_pkg::*;
(
    input logic      clk,
    input logic      reset_n,
    input logic      mmio_read,
    input logic      mmio_write,
    input logic      mmio_readdatavalid,
    input logic      mmio_writeresponsevalid,
    input logic      wr_write,
    input logic      wr_waitrequest,
    input t_mem_addr wr_address,
    input t_line     wr_writedata,
    input logic      run,
    input t_state    state
);
    timeunit 1ns;
    timeprecision 1ps;

    // Number of assertion failures seen so far
    int assert_failures = 0;

    // ==================================================
    // MMIO response timing
    // ==================================================

    // A read is answered exactly one cycle later, and nothing answers a cycle without a read
    read_response: assert property (@(posedge clk) disable iff (!reset_n)
        1'b1 |=> (mmio_readdatavalid == $past(mmio_read)))
    else
    begin
        assert_failures++;
        $error("Read response is not exactly one cycle after the read request");
    end

    // Same rule for the write response
    write_response: assert property (@(posedge clk) disable iff (!reset_n)
        1'b1 |=> (mmio_writeresponsevalid == $past(mmio_write)))
    else
    begin
        assert_failures++;
        $error("Write response is not exactly one cycle after the write request");
    end

    // ==================================================
    // Memory channel and FSM
    // ==================================================

    // A stalled request stays on offer with address and data unchanged
    stall_stable: assert property (@(posedge clk) disable iff (!reset_n)
        (wr_write && wr_waitrequest) |=>
            (wr_write && $stable(wr_address) && $stable(wr_writedata)))
    else
    begin
        assert_failures++;
        $error("Memory request changed while waitrequest was high");
    end

    // The FSM leaves idle only after a host write, so run stays low otherwise
    idle_not_running: assert property (@(posedge clk) disable iff (!reset_n)
        (state == STATE_IDLE && !mmio_write) |=> !run)
    else
    begin
        assert_failures++;
        $error("Run went high without a host write while the control FSM was idle");
    end

endmodule

// The top level sees both ports and reaches the control FSM state below it
bind hello_top hello_chk hello_chk_inst
(
    .clk                     (clk),
    .reset_n                 (reset_n),
    .mmio_read               (mmio_read),
    .mmio_write              (mmio_write),
    .mmio_readdatavalid      (mmio_readdatavalid),
    .mmio_writeresponsevalid (mmio_writeresponsevalid),
    .wr_write                (wr_write),
    .wr_waitrequest          (wr_waitrequest),
    .wr_address              (wr_address),
    .wr_writedata            (wr_writedata),
    .run                     (run),
    .state                   (hello_ctrl_inst.state)
);

//--- verif/hello_tb_clock.sv
/*
 * Hello testbench clock and reset generator
 */

module hello_tb_clock
#(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
)
(
    output logic clk,
    output logic reset_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Reset is released on a falling edge, away from the sampling edge
    initial
    begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

//--- source/hello_top.sv
/*
 * Hello accelerator top level
 * Connects the MMIO register block, the job control and the write engine
 */

module hello_top import hello_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    // Host MMIO port
    input  logic       mmio_read,
    input  logic       mmio_write,
    input  t_mmio_addr mmio_address,
    input  t_mmio_data mmio_writedata,
    output logic       mmio_readdatavalid,
    output t_mmio_data mmio_readdata,
    output logic       mmio_writeresponsevalid,

    // Host memory write channel
    input  logic       wr_waitrequest,
    output logic       wr_write,
    output t_mem_addr  wr_address,
    output t_line      wr_writedata
);

    // Job parameters from the register block
    logic      start;
    t_mem_addr job_addr;
    t_count    job_count;

    // Status and strobes between control and the write engine
    logic      busy;
    t_count    lines_written;
    logic      load;
    logic      run;
    logic      line_accepted;

    hello_csr hello_csr_inst
    (
        .clk                     (clk),
        .reset_n                 (reset_n),
        .mmio_read               (mmio_read),
        .mmio_write              (mmio_write),
        .mmio_address            (mmio_address),
        .mmio_writedata          (mmio_writedata),
        .mmio_readdatavalid      (mmio_readdatavalid),
        .mmio_readdata           (mmio_readdata),
        .mmio_writeresponsevalid (mmio_writeresponsevalid),
        .busy                    (busy),
        .lines_written           (lines_written),
        .start                   (start),
        .job_addr                (job_addr),
        .job_count               (job_count)
    );

    hello_ctrl hello_ctrl_inst
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .start         (start),
        .job_count     (job_count),
        .line_accepted (line_accepted),
        .load          (load),
        .run           (run),
        .busy          (busy),
        .lines_written (lines_written)
    );

    hello_writer hello_writer_inst
    (
        .clk            (clk),
        .reset_n        (reset_n),
        .load           (load),
        .run            (run),
        .job_addr       (job_addr),
        .wr_waitrequest (wr_waitrequest),
        .wr_write       (wr_write),
        .wr_address     (wr_address),
        .wr_writedata   (wr_writedata),
        .line_accepted  (line_accepted)
    );

endmodule

//--- source/hello_writer.sv
/*
 * Hello memory write engine
 * Formats greeting lines and walks consecutive host line addresses
 */

`include "hello_settings.svh"

module hello_writer import hello_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,

    // Job control
    input  logic      load,
    input  logic      run,
    input  t_mem_addr job_addr,

    // Write request channel to host memory
    input  logic      wr_waitrequest,
    output logic      wr_write,
    output t_mem_addr wr_address,
    output t_line     wr_writedata,

    output logic      line_accepted
);

    t_count line_index;

    // One line is always on offer while the job runs
    assign wr_write = run;

    // Handshake completes when the memory is not stalling
    assign line_accepted = wr_write && !wr_waitrequest;

    // ==================================================
    // Address and index counters
    // ==================================================

    // Both hold still under waitrequest, which keeps the request stable
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_address <= '0;
            line_index <= '0;
        end
        else if (load)
        begin
            wr_address <= job_addr;
            line_index <= '0;
        end
        else if (line_accepted)
        begin
            wr_address <= wr_address + 1'b1;
            line_index <= line_index + 1'b1;
        end
    end

    // Greeting in the low bytes, line index in the top byte
    always_comb
    begin
        wr_writedata = '0;
        wr_writedata[`HELLO_GREETING_WIDTH-1:0] = `HELLO_GREETING;
        wr_writedata[`HELLO_LINE_WIDTH-1 -: `HELLO_COUNT_WIDTH] = line_index;
    end

endmodule

//--- source/hello_ctrl.sv
/*
 * Hello job control
 * FSM that counts accepted lines and ends the job after the last one
 */

module hello_ctrl import hello_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,

    // Job launch and length from the register block
    input  logic   start,
    input  t_count job_count,

    // One strobe per line taken by host memory
    input  logic   line_accepted,

    output logic   load,
    output logic   run,
    output logic   busy,
    output t_count lines_written
);

    t_state state;
    logic   last_line;

    // A start is honoured only from idle
    assign load = start && (state == STATE_IDLE);

    assign run  = (state == STATE_RUN);
    assign busy = (state != STATE_IDLE);

    // Count holds lines minus one, so the final acceptance is seen
    // while the running total still equals it
    assign last_line = line_accepted && (lines_written == job_count);

    // ==================================================
    // State and line counter
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state         <= STATE_IDLE;
            lines_written <= '0;
        end
        else
        begin
            case (state)
                STATE_IDLE:
                begin
                    if (load)
                    begin
                        state         <= STATE_RUN;
                        lines_written <= '0;
                    end
                end
                STATE_RUN:
                begin
                    if (line_accepted)
                    begin
                        lines_written <= lines_written + 1'b1;
                    end
                    // Total stays readable in status after the job ends
                    if (last_line)
                    begin
                        state <= STATE_IDLE;
                    end
                end
                default:
                begin
                    state <= STATE_IDLE;
                end
            endcase
        end
    end

endmodule

//--- source/hello_csr.sv
/*
 * Hello MMIO register block
 * Answers host reads, acknowledges writes and raises the job start
 */

`include "hello_settings.svh"

module hello_csr import hello_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    // Host MMIO port, every request is taken in its own cycle
    input  logic       mmio_read,
    input  logic       mmio_write,
    input  t_mmio_addr mmio_address,
    input  t_mmio_data mmio_writedata,
    output logic       mmio_readdatavalid,
    output t_mmio_data mmio_readdata,
    output logic       mmio_writeresponsevalid,

    // Job status from the control FSM
    input  logic       busy,
    input  t_count     lines_written,

    // Job parameters towards control and the write engine
    output logic       start,
    output t_mem_addr  job_addr,
    output t_count     job_count
);

    // ==================================================
    // Write decode
    // ==================================================

    logic       addr_write;
    logic       count_write;
    t_mem_addr  mem_addr_q;
    t_mmio_data status_word;

    assign addr_write  = mmio_write && (mmio_address == CSR_MEM_ADDR);
    assign count_write = mmio_write && (mmio_address == CSR_LINE_COUNT);

    // Only an address write made while idle launches a job
    assign start = addr_write && !busy;

    // The write engine samples the address in the start cycle itself,
    // so the incoming data is forwarded past the register
    assign job_addr = addr_write ? t_mem_addr'(mmio_writedata) : mem_addr_q;

    // Registers are frozen for the whole job
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mem_addr_q <= '0;
            job_count  <= '0;
        end
        else if (!busy)
        begin
            if (addr_write)
            begin
                mem_addr_q <= t_mem_addr'(mmio_writedata);
            end
            // Count holds lines minus one
            if (count_write)
            begin
                job_count <= t_count'(mmio_writedata);
            end
        end
    end

    // Write response one cycle after the request, busy or not
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mmio_writeresponsevalid <= 1'b0;
        end
        else
        begin
            mmio_writeresponsevalid <= mmio_write;
        end
    end

    // ==================================================
    // Read response
    // ==================================================

    // Bit 0 is busy, bits 15:8 count the lines of the current job
    always_comb
    begin
        status_word       = '0;
        status_word[0]    = busy;
        status_word[15:8] = lines_written;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mmio_readdatavalid <= 1'b0;
        end
        else
        begin
            mmio_readdatavalid <= mmio_read;
        end
    end

    // Read data is payload and follows the address every cycle
    always_ff @(posedge clk)
    begin
        case (t_csr_index'(mmio_address))
            CSR_DFH:
            begin
                // Feature type AFU, sole and last entry of the list
                mmio_readdata        <= '0;
                mmio_readdata[63:60] <= 4'h1;
                mmio_readdata[40]    <= 1'b1;
            end
            CSR_ID_L:   mmio_readdata <= 64'(`HELLO_AFU_ID);
            CSR_ID_H:   mmio_readdata <= 64'(`HELLO_AFU_ID >> 64);
            CSR_STATUS: mmio_readdata <= status_word;
            // Reserved words and anything unmapped read as zero
            default:    mmio_readdata <= '0;
        endcase
    end

endmodule

//--- source/hello_pkg.sv
/*
 * Hello accelerator package
 * Data types, FSM states and MMIO register indices
 */

`include "hello_settings.svh"

package hello_pkg;

    // Width-sized data types
    typedef logic [`HELLO_MEM_ADDR_WIDTH-1:0] t_mem_addr;
    typedef logic [`HELLO_LINE_WIDTH-1:0] t_line;
    typedef logic [`HELLO_MMIO_DATA_WIDTH-1:0] t_mmio_data;
    typedef logic [`HELLO_MMIO_ADDR_WIDTH-1:0] t_mmio_addr;
    typedef logic [`HELLO_COUNT_WIDTH-1:0] t_count;

    // Job control states
    typedef enum logic [0:0]
    {
        STATE_IDLE,
        STATE_RUN
    } t_state;

    // Read space, the first five words form the device feature list entry
    typedef enum logic [`HELLO_MMIO_ADDR_WIDTH-1:0]
    {
        CSR_DFH    = 0,
        CSR_ID_L   = 1,
        CSR_ID_H   = 2,
        CSR_RSVD0  = 3,
        CSR_RSVD1  = 4,
        CSR_STATUS = 5
    } t_csr_index;

    // Write space is decoded on its own and reuses the low indices
    typedef enum logic [`HELLO_MMIO_ADDR_WIDTH-1:0]
    {
        CSR_MEM_ADDR   = 0,
        CSR_LINE_COUNT = 1
    } t_csr_wr_index;

endpackage

//--- source/hello_settings.svh
/*
 * Hello accelerator settings
 * Bus widths, the accelerator identifier and the greeting line pattern
 */

`ifndef HELLO_SETTINGS_SVH
`define HELLO_SETTINGS_SVH

// Host memory side, addressed in whole 512-bit lines
`define HELLO_MEM_ADDR_WIDTH 32
`define HELLO_LINE_WIDTH 512

// MMIO side, addressed in 64-bit words
`define HELLO_MMIO_ADDR_WIDTH 4
`define HELLO_MMIO_DATA_WIDTH 64

// Line count register and line index width
`define HELLO_COUNT_WIDTH 8

// Identifier that host software matches before it uses the block
`define HELLO_AFU_ID 128'h3f9e2a6b_c41d_4e87_a05b_7d2c19e06f34

// "Hello world!" in ASCII, first character in the lowest byte
`define HELLO_GREETING_WIDTH 96
`define HELLO_GREETING 96'h21646c72_6f77206f_6c6c6548

`endif
